//--- meshRouter.f
+incdir+common
common/meshPkg.sv
inputUnit/flitFifo.sv
inputUnit/routeCompute.sv
inputUnit/inputUnit.sv
verilog/switchStage.sv
verilog/meshRouter.sv
testbench/meshRouter_sva.sv
testbench/meshRouter_tb.sv

//--- Makefile
# Verilator build and run of the router node testbench

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module meshRouter_tb \
	  -f meshRouter.f -o meshRouter_sim
	./obj_dir/meshRouter_sim | tee sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- testbench/meshRouter_tb.sv
`timescale 1ns/1ps
`include "mesh_macros.svh"

module meshRouter_tb import meshPkg::*;
  ();

  localparam int NPORTS      = $bits(portMaskT);
  localparam int ARRIVE_MAX  = 4 * `DEADLOCK_LIMIT;   // Cycles a flit may take to show up
  localparam int RUN_CYCLES  = 5 + 22 * 5 + 4 * `DEADLOCK_LIMIT + 3 * `FIFO_DEPTH + 30;
  localparam int WATCHDOG_NS = (RUN_CYCLES + 100) * 8;

  logic     clk;
  logic     rstN;
  flitT     inFlit [NPORTS];
  portMaskT inValid;
  portMaskT inHold;
  flitT     outFlit [NPORTS];
  portMaskT outValid;
  portMaskT outHold;
  portMaskT unproductive;

  int   seed      = 32'he564ed86;   // Payload stream
  int   cycleNo   = 0;              // Rising edges so far
  portE lastLocal = PORT_WEST;      // Last winner at the local output
  int   recPort [$];                // Output pulses seen by the monitor
  flitT recFlit [$];
  int   recCycle [$];

  meshRouter #(.xLoc(2'd1), .yLoc(2'd1)) meshRouter_i
   (.clk          (clk),
    .rstN         (rstN),
    .inFlit       (inFlit),
    .inValid      (inValid),
    .inHold       (inHold),
    .outFlit      (outFlit),
    .outValid     (outValid),
    .outHold      (outHold),
    .unproductive (unproductive));

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period
  end

  always @(posedge clk)
    cycleNo <= cycleNo + 1;

  // Outputs are settled mid-cycle
  always @(negedge clk)
  begin
    for (int p = 0; p < NPORTS; p++)
    begin
      if (rstN && outValid[p])
      begin
        recPort.push_back(p);
        recFlit.push_back(outFlit[p]);
        recCycle.push_back(cycleNo);
      end
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Errors found");
    $fatal(1, "watchdog expired");
  end

  task automatic checkEq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
      $display("Errors found");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "stopped at first error");
  endtask

  function automatic flitT makeFlit(input int x, input int y, input int rr);
    flitT f;
    f.xDest   = coordT'(x);
    f.yDest   = coordT'(y);
    f.reroute = misCountT'(rr);
    f.payload = $random(seed);
    return f;
  endfunction

  task automatic setHold(input portMaskT m);
    @(posedge clk);
    outHold <= m;
  endtask

  task automatic sendFlit(input portE port, input flitT f, output int sent);
    @(negedge clk);
    while (inHold[port])   // No strobe while the FIFO is full
      @(negedge clk);
    @(posedge clk);
    inFlit[port]  <= f;
    inValid[port] <= 1'b1;
    @(negedge clk);
    sent = cycleNo;   // Cycle carrying the strobe
    @(posedge clk);
    inValid[port] <= 1'b0;   // Flit written at this edge
  endtask

  // Negative latency skips the timing check
  task automatic expectFlit(input portE port, input flitT f, input int sent, input int latency);
    int   waited;
    int   gotPort;
    flitT gotFlit;
    int   gotCycle;
    waited = 0;
    while (recPort.size() == 0)
    begin
      @(posedge clk);
      waited++;
      if (waited > ARRIVE_MAX)
        failRun($sformatf("No flit arrived although one was expected on port %0d", port));
    end
    gotPort  = recPort.pop_front();
    gotFlit  = recFlit.pop_front();
    gotCycle = recCycle.pop_front();
    checkEq("outPort", 64'(gotPort), 64'(port));
    checkEq("outFlit", 64'(gotFlit), 64'(f));
    if (latency >= 0)
      checkEq("latency", 64'(gotCycle - sent), 64'(latency));
  endtask

  task automatic minimalRouting();
    int   dx [4]  = '{3, 0, 1, 1};   // East, west, north, south of (1,1)
    int   dy [4]  = '{1, 1, 0, 3};
    portE dst [4] = '{PORT_EAST, PORT_WEST, PORT_NORTH, PORT_SOUTH};
    flitT f;
    int   sent;
    for (int p = 0; p < NPORTS; p++)
    begin
      for (int d = 0; d < 4; d++)
      begin
        f = makeFlit(dx[d], dy[d], d % 3);
        sendFlit(portE'(p), f, sent);
        expectFlit(dst[d], f, sent, 2);
      end
    end
  endtask

  task automatic ejection();
    flitT f;
    int   sent;
    f = makeFlit(1, 1, 1);
    sendFlit(PORT_NORTH, f, sent);
    expectFlit(PORT_LOCAL, f, sent, 2);
    lastLocal = PORT_NORTH;
  endtask

  task automatic adaptivity();
    flitT f;
    int   sent;
    setHold(5'b00100);   // East held, south still free
    f = makeFlit(2, 2, 0);
    sendFlit(PORT_LOCAL, f, sent);
    @(negedge clk);
    checkEq("unproductive", 64'(unproductive[PORT_LOCAL]), 64'd0);
    expectFlit(PORT_SOUTH, f, sent, 2);
    setHold('0);
  endtask

  task automatic deadlockEscape();
    flitT f;
    flitT g;
    int   sent;
    int   waited;
    setHold(5'b01100);   // Both productive ports of (2,2) held
    f = makeFlit(2, 2, 0);
    sendFlit(PORT_WEST, f, sent);
    waited = 0;
    while (!unproductive[PORT_WEST])
    begin
      @(negedge clk);
      waited++;
      if (waited > ARRIVE_MAX)
        failRun("The blocked flit never raised unproductive");
    end
    g         = f;
    g.reroute = f.reroute + 1'b1;   // West is the first free unproductive port
    expectFlit(PORT_WEST, g, sent, `DEADLOCK_LIMIT + 2);
    f = makeFlit(2, 2, `UNPRODUCTIVE);   // No misroutes left
    sendFlit(PORT_WEST, f, sent);
    repeat (3 * `DEADLOCK_LIMIT)
    begin
      @(negedge clk);
      checkEq("unproductive", 64'(unproductive[PORT_WEST]), 64'd0);
      checkEq("pending flits", 64'(recPort.size()), 64'd0);
    end
    setHold(5'b00100);   // Release south
    expectFlit(PORT_SOUTH, f, sent, -1);
    setHold('0);
  endtask

  task automatic backPressure();
    flitT f [`FIFO_DEPTH];
    int   sent;
    setHold('1);   // Every output held so no escape exists
    for (int i = 0; i < `FIFO_DEPTH; i++)
    begin
      f[i] = makeFlit(3, 1, 0);
      sendFlit(PORT_LOCAL, f[i], sent);
    end
    @(negedge clk);
    checkEq("inHold", 64'(inHold[PORT_LOCAL]), 64'd1);
    setHold('0);
    for (int i = 0; i < `FIFO_DEPTH; i++)
      expectFlit(PORT_EAST, f[i], sent, -1);
  endtask

  task automatic arbitration();
    flitT f [NPORTS];
    int   sent [NPORTS];
    int   idx;
    int   n;
    portE start;
    for (int p = 1; p < NPORTS; p++)
      f[p] = makeFlit(1, 1, p % 3);
    fork
      sendFlit(PORT_NORTH, f[1], sent[1]);
      sendFlit(PORT_EAST, f[2], sent[2]);
      sendFlit(PORT_SOUTH, f[3], sent[3]);
      sendFlit(PORT_WEST, f[4], sent[4]);
    join
    n     = 0;
    start = lastLocal;   // Pointer of the local output before the burst
    for (int k = 1; k <= NPORTS; k++)
    begin
      idx = (int'(start) + k) % NPORTS;   // Search begins after the last winner
      if (idx != PORT_LOCAL)
      begin
        expectFlit(PORT_LOCAL, f[idx], sent[idx], 2 + n);   // One per cycle
        lastLocal = portE'(idx);
        n++;
      end
    end
  endtask

  initial
  begin
    rstN    <= 1'b0;
    inValid <= '0;
    outHold <= '0;
    for (int p = 0; p < NPORTS; p++)
      inFlit[p] <= '0;
    repeat (5) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    checkEq("outValid", 64'(outValid), 64'd0);
    checkEq("inHold", 64'(inHold), 64'd0);
    checkEq("unproductive", 64'(unproductive), 64'd0);
    minimalRouting();
    ejection();
    adaptivity();
    deadlockEscape();
    backPressure();
    arbitration();
    repeat (4) @(posedge clk);
    checkEq("pending flits", 64'(recPort.size()), 64'd0);   // Nothing extra left the router
    $display("No errors");
    $finish;
  end

endmodule

//--- testbench/meshRouter_sva.sv
`timescale 1ns/1ps

module meshRouter_sva import meshPkg::*;
   (input logic     clk,
    input logic     rstN,
    input portMaskT grant,                          // Pops per input unit
    input portMaskT request [$bits(portMaskT)],     // Output wanted by each input
    input portMaskT inValid,
    input portMaskT inHold,
    input portMaskT outValid,
    input portMaskT outHold);

  portMaskT granted [$bits(portMaskT)];   // Per output, the inputs granted towards it

  always_comb
  begin
    for (int o = 0; o < $bits(portMaskT); o++)
      for (int i = 0; i < $bits(portMaskT); i++)
        granted[o][i] = grant[i] && request[i][o];
  end

  for (genvar o = 0; o < $bits(portMaskT); o++)
  begin : perOutput
    assert property (@(posedge clk) disable iff (!rstN) $onehot0(granted[o]))
      else $error("Output %0d granted to more than one input", o);
    assert property (@(posedge clk) disable iff (!rstN) outValid[o] |-> !$past(outHold[o]))
      else $error("Output %0d sent a flit while it was held", o);   // Grant cycle was held
  end

  assert property (@(posedge clk) disable iff (!rstN) (inValid & inHold) == '0)
    else $error("Sender wrote into a full input FIFO");

endmodule

bind meshRouter meshRouter_sva meshRouter_sva_i
 (.clk      (clk),
  .rstN     (rstN),
  .grant    (grant),
  .request  (request),
  .inValid  (inValid),
  .inHold   (inHold),
  .outValid (outValid),
  .outHold  (outHold));

//--- verilog/meshRouter.sv
`timescale 1ns/1ps

module meshRouter import meshPkg::*;
  #(parameter coordT xLoc = '0,   // Column of this node
    parameter coordT yLoc = '0)   // Row of this node
   (input  logic     clk,
    input  logic     rstN,
    input  flitT     inFlit [$bits(portMaskT)],    // Input links, indexed by portE
    input  portMaskT inValid,
    output portMaskT inHold,                       // FIFO full flags
    output flitT     outFlit [$bits(portMaskT)],   // Output links, indexed by portE
    output portMaskT outValid,
    input  portMaskT outHold,                      // Back-pressure from the neighbours
    output portMaskT unproductive);                // Misroute flags per input

  flitT     headFlit [$bits(portMaskT)];   // Routed heads into the switch
  portMaskT request [$bits(portMaskT)];    // Output requests per input
  portMaskT grant;                         // Pops per input

  // One input unit per port
  for (genvar i = 0; i < $bits(portMaskT); i++)
  begin : inPort
    inputUnit #(.xLoc(xLoc), .yLoc(yLoc)) inputUnit_i
     (.clk          (clk),
      .rstN         (rstN),
      .inFlit       (inFlit[i]),
      .inValid      (inValid[i]),
      .inHold       (inHold[i]),
      .outHold      (outHold),
      .grant        (grant[i]),
      .headFlit     (headFlit[i]),
      .request      (request[i]),
      .unproductive (unproductive[i]));
  end

  // Allocation, crossbar and output registers
  switchStage switchStage_i
   (.clk      (clk),
    .rstN     (rstN),
    .headFlit (headFlit),
    .request  (request),
    .outHold  (outHold),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid));

endmodule

//--- verilog/switchStage.sv
`timescale 1ns/1ps

module switchStage import meshPkg::*;
   (input  logic     clk,
    input  logic     rstN,
    input  flitT     headFlit [$bits(portMaskT)],   // Routed head flit of each input
    input  portMaskT request [$bits(portMaskT)],    // Output wanted by each input
    input  portMaskT outHold,                       // Downstream back-pressure per output
    output portMaskT grant,                         // One bit per input unit
    output flitT     outFlit [$bits(portMaskT)],    // Registered output flits
    output portMaskT outValid);                     // One-cycle valid per output

  localparam int NPORTS = $bits(portMaskT);

  portE     rrPtr [NPORTS];      // Input served last by each output
  portE     winner [NPORTS];     // Input chosen this cycle
  portMaskT grantMat [NPORTS];   // Per output, one-hot over inputs
  portMaskT outGrant;            // Outputs loading a flit at this edge

  // Round-robin search starts just after the last winner
  always_comb
  begin : allocate
    int idx;
    for (int o = 0; o < NPORTS; o++)
    begin
      grantMat[o] = '0;
      winner[o]   = rrPtr[o];
      outGrant[o] = 1'b0;
      for (int k = 1; k <= NPORTS; k++)
      begin
        idx = (int'(rrPtr[o]) + k) % NPORTS;
        if (!outHold[o] && !outGrant[o] && request[idx][o])   // Held outputs grant nothing
        begin
          grantMat[o][idx] = 1'b1;
          winner[o]        = portE'(idx);
          outGrant[o]      = 1'b1;
        end
      end
    end
  end

  // Inputs ask for one output each, so the OR stays one-hot per input
  always_comb
  begin
    grant = '0;
    for (int o = 0; o < NPORTS; o++)
      grant = grant | grantMat[o];
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      outValid <= '0;
      for (int o = 0; o < NPORTS; o++)
        rrPtr[o] <= PORT_WEST;   // First search begins at local
    end
    else
    begin
      outValid <= outGrant;   // Falls when no grant occurs
      for (int o = 0; o < NPORTS; o++)
      begin
        if (outGrant[o])
          rrPtr[o] <= winner[o];
      end
    end
  end

  // Crossbar into the output registers, which hold between grants
  always_ff @(posedge clk)
  begin
    for (int o = 0; o < NPORTS; o++)
    begin
      if (outGrant[o])
        outFlit[o] <= headFlit[winner[o]];
    end
  end

endmodule

//--- inputUnit/inputUnit.sv
`timescale 1ns/1ps

module inputUnit import meshPkg::*;
  #(parameter coordT xLoc = '0,   // Column of this node
    parameter coordT yLoc = '0)   // Row of this node
   (input  logic     clk,
    input  logic     rstN,
    input  flitT     inFlit,          // Flit on the input link
    input  logic     inValid,         // Write strobe from the sender
    output logic     inHold,          // Buffer full, sender must wait
    input  portMaskT outHold,         // Back-pressure on the router outputs
    input  logic     grant,           // Switch took the head flit
    output flitT     headFlit,        // Routed head flit towards the switch
    output portMaskT request,         // Output port wanted by the head flit
    output logic     unproductive);   // Misroute in progress

  flitT rawHead;   // Head flit as stored
  logic empty;

  // Grant pops the buffer at the edge that loads the output register
  flitFifo flitFifo_i
   (.clk      (clk),
    .rstN     (rstN),
    .wrEn     (inValid),
    .wrFlit   (inFlit),
    .rdEn     (grant),
    .headFlit (rawHead),
    .full     (inHold),
    .empty    (empty));

  routeCompute #(.xLoc(xLoc), .yLoc(yLoc)) routeCompute_i
   (.clk          (clk),
    .rstN         (rstN),
    .headFlit     (rawHead),
    .empty        (empty),
    .outHold      (outHold),
    .grant        (grant),
    .request      (request),
    .unproductive (unproductive),
    .waitCount    (),   // Observed only inside route computation
    .routedFlit   (headFlit));

endmodule

//--- inputUnit/routeCompute.sv
`timescale 1ns/1ps
`include "mesh_macros.svh"

module routeCompute import meshPkg::*;
  #(parameter coordT xLoc = '0,   // Column of this node
    parameter coordT yLoc = '0)   // Row of this node
   (input  logic      clk,
    input  logic      rstN,
    input  flitT      headFlit,       // Raw flit at the FIFO head
    input  logic      empty,
    input  portMaskT  outHold,        // Back-pressure from the neighbours
    input  logic      grant,          // Head flit leaves at this edge
    output portMaskT  request,        // One-hot, zero when nothing to send
    output logic      unproductive,   // High while a misroute is requested
    output waitCountT waitCount,      // Cycles blocked on productive ports
    output flitT      routedFlit);    // Head flit with its misroute count updated

  localparam coordT edgeLoc = coordT'(`MESH_WIDTH - 1);   // Last row and column

  portMaskT productive;   // Ports that bring the flit closer
  portMaskT meshPorts;    // Neighbour ports that exist at this location
  portMaskT freeProd;
  portMaskT freeMis;
  logic     blocked;
  logic     escape;

  // Fixed preference, X before Y, local last
  function automatic portMaskT pickPort(input portMaskT cand);
    portMaskT pick;
    pick = '0;
    if (cand[PORT_EAST])
      pick[PORT_EAST] = 1'b1;
    else if (cand[PORT_WEST])
      pick[PORT_WEST] = 1'b1;
    else if (cand[PORT_SOUTH])
      pick[PORT_SOUTH] = 1'b1;
    else if (cand[PORT_NORTH])
      pick[PORT_NORTH] = 1'b1;
    else if (cand[PORT_LOCAL])
      pick[PORT_LOCAL] = 1'b1;
    return pick;
  endfunction

  always_comb
  begin
    productive             = '0;
    productive[PORT_EAST]  = headFlit.xDest > xLoc;
    productive[PORT_WEST]  = headFlit.xDest < xLoc;
    productive[PORT_SOUTH] = headFlit.yDest > yLoc;
    productive[PORT_NORTH] = headFlit.yDest < yLoc;
    productive[PORT_LOCAL] = (headFlit.xDest == xLoc) && (headFlit.yDest == yLoc);
    meshPorts              = '0;
    meshPorts[PORT_EAST]   = xLoc < edgeLoc;   // No misroute off the mesh edge
    meshPorts[PORT_WEST]   = xLoc > '0;
    meshPorts[PORT_SOUTH]  = yLoc < edgeLoc;
    meshPorts[PORT_NORTH]  = yLoc > '0;
  end

  assign freeProd = productive & ~outHold;
  assign freeMis  = meshPorts & ~productive & ~outHold;
  assign blocked  = !empty && (freeProd == '0);   // Every productive port held
  assign escape   = blocked && (waitCount >= waitCountT'(`DEADLOCK_LIMIT))
                    && (headFlit.reroute < misCountT'(`UNPRODUCTIVE)) && (freeMis != '0);

  always_comb
  begin
    routedFlit   = headFlit;
    request      = '0;
    unproductive = 1'b0;
    if (!empty && freeProd != '0)
      request = pickPort(freeProd);
    else if (escape)
    begin
      request            = pickPort(freeMis);           // Step away from the destination
      unproductive       = 1'b1;
      routedFlit.reroute = headFlit.reroute + 1'b1;   // Count the misroute in the flit
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
      waitCount <= '0;
    else if (grant || empty)
      waitCount <= '0;
    else if (blocked && waitCount < waitCountT'(`DEADLOCK_LIMIT))
      waitCount <= waitCount + 1'b1;   // Saturates at the limit
  end

endmodule

//--- inputUnit/flitFifo.sv
`timescale 1ns/1ps
`include "mesh_macros.svh"

module flitFifo import meshPkg::*;
   (input  logic clk,
    input  logic rstN,
    input  logic wrEn,         // Write strobe from the link
    input  flitT wrFlit,
    input  logic rdEn,         // Pop the head, driven by the switch grant
    output flitT headFlit,     // Oldest flit, read combinationally
    output logic full,
    output logic empty);

  localparam int DEPTH = `FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  flitT             mem [DEPTH];   // Flit storage
  logic [PTR_W-1:0] wrPtr;         // Next slot to fill
  logic [PTR_W-1:0] rdPtr;         // Current head slot
  logic [CNT_W-1:0] count;         // Flits held
  logic             doWrite;
  logic             doRead;

  function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;   // Wrap for any depth
    return ptr + 1'b1;
  endfunction

  assign full     = (count == CNT_W'(DEPTH));
  assign empty    = (count == '0);
  assign doRead   = rdEn && !empty;
  assign doWrite  = wrEn && (!full || doRead);   // A full FIFO takes a write that pairs with a pop
  assign headFlit = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWrite)
        wrPtr <= nextPtr(wrPtr);
      if (doRead)
        rdPtr <= nextPtr(rdPtr);
      if (doWrite && !doRead)
        count <= count + 1'b1;
      else if (doRead && !doWrite)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (doWrite)
      mem[wrPtr] <= wrFlit;
  end

endmodule

//--- common/meshPkg.sv
`include "mesh_macros.svh"

package meshPkg;

  typedef logic [`COORD_W-1:0] coordT;                          // One X or Y coordinate
  typedef logic [31:0] payloadT;                                // Flit payload
  typedef logic [`MIS_W-1:0] misCountT;                         // Misroutes taken so far
  typedef logic [$clog2(`DEADLOCK_LIMIT + 1)-1:0] waitCountT;   // Blocked cycle counter

  // One bit per port, bit 0 is local, then north, east, south, west
  typedef logic [4:0] portMaskT;

  typedef enum logic [2:0]
  {
    PORT_LOCAL = 3'd0,   // Injection and ejection
    PORT_NORTH = 3'd1,   // Towards lower Y
    PORT_EAST  = 3'd2,   // Towards higher X
    PORT_SOUTH = 3'd3,   // Towards higher Y
    PORT_WEST  = 3'd4    // Towards lower X
  } portE;

  // A flit is a whole packet here
  typedef struct packed
  {
    coordT    xDest;     // Destination column
    coordT    yDest;     // Destination row
    misCountT reroute;   // Misroutes taken on the way
    payloadT  payload;
  } flitT;

endpackage

//--- common/mesh_macros.svh
`ifndef MESH_MACROS_SVH
`define MESH_MACROS_SVH

// Mesh geometry
`define MESH_WIDTH 4        // Nodes per row and per column
`define COORD_W 2           // Bits of one coordinate

// Input buffering
`define FIFO_DEPTH 4        // Flits per input FIFO

// Deadlock escape
`define DEADLOCK_LIMIT 8    // Blocked cycles before a misroute may be taken
`define UNPRODUCTIVE 2      // Misroutes allowed per flit
`define MIS_W 2             // Bits of the misroute count

`endif
